/* lc3b_cache_pkg.sv */
`default_nettype none

package lc3b_cache_pkg;

    // geometry of one cache
    localparam int word_bits   = 16;
    localparam int line_bytes  = 16;
    localparam int num_sets    = 8;
    localparam int offset_bits = 4;
    localparam int set_bits    = 3;
    localparam int tag_bits    = 9;

    typedef logic [word_bits-1:0]    lc3b_word;
    typedef logic [1:0]              lc3b_mask;
    typedef logic [8*line_bytes-1:0] lc3b_line;
    typedef logic [tag_bits-1:0]     lc3b_tag;
    typedef logic [set_bits-1:0]     lc3b_set;

    // tag in the top bits, byte offset within the line in the bottom bits
    typedef struct packed {
        lc3b_tag                tag;
        lc3b_set                set;
        logic [offset_bits-1:0] offset;
    } lc3b_addr_fields;

    // the same address word seen as a plain byte address or split into fields
    typedef union packed {
        lc3b_word        raw;
        lc3b_addr_fields fields;
    } lc3b_addr_u;

endpackage

`default_nettype wire

/* mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
    import lc3b_cache_pkg::*;

    logic     strobe;
    logic     write;
    lc3b_word addr;
    lc3b_line wdata;
    lc3b_line rdata;
    logic     resp;

    // requester side holds its request steady until resp
    modport cache (
        output strobe, write, addr, wdata,
        input  rdata, resp
    );

    modport arbiter (
        input  strobe, write, addr, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

/* cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_strobe,
    input  logic cpu_write,
    input  logic hit,
    input  logic victim_dirty,
    input  logic mem_resp,
    output logic ctrl_hit,
    output logic ctrl_write,
    output logic ctrl_reload,
    output logic mem_we,
    output logic mem_strobe
);

    typedef enum logic [2:0] {
        rw_hit,
        load_addr,
        write_back,
        mem_reset,
        reload
    } state_t;

    state_t state;
    state_t next_state;

    logic cpu_load;
    logic cpu_store;
    logic miss;

    assign cpu_load  = cpu_strobe & ~cpu_write;
    assign cpu_store = cpu_strobe & cpu_write;

    // loads and stores both allocate on a miss
    assign miss = (cpu_load | cpu_store) & ~hit;

    always_comb begin
        ctrl_hit    = 1'b0;
        ctrl_write  = 1'b0;
        ctrl_reload = 1'b0;
        mem_we      = 1'b0;
        mem_strobe  = 1'b0;
        case (state)
            rw_hit: begin
                ctrl_hit = cpu_load | cpu_store;
            end
            write_back: begin
                ctrl_write = 1'b1;
                mem_we     = 1'b1;
                mem_strobe = 1'b1;
            end
            reload: begin
                ctrl_reload = 1'b1;
                mem_strobe  = 1'b1;
            end
            // load_addr and mem_reset drop the strobe so the arbiter can rotate
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            rw_hit: begin
                if (miss) begin
                    if (victim_dirty) begin
                        next_state = load_addr;
                    end else begin
                        next_state = mem_reset;
                    end
                end
            end
            load_addr: begin
                next_state = write_back;
            end
            write_back: begin
                if (mem_resp) begin
                    next_state = mem_reset;
                end
            end
            mem_reset: begin
                next_state = reload;
            end
            reload: begin
                // the access is answered as a hit on the following cycle
                if (mem_resp) begin
                    next_state = rw_hit;
                end
            end
            default: begin
                next_state = rw_hit;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rw_hit;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_strobe,
    input  logic                     cpu_write,
    input  lc3b_cache_pkg::lc3b_mask cpu_mask,
    input  lc3b_cache_pkg::lc3b_word cpu_addr,
    input  lc3b_cache_pkg::lc3b_word cpu_wdata,
    output lc3b_cache_pkg::lc3b_word cpu_rdata,
    output logic                     cpu_resp,
    input  logic                     ctrl_hit,
    input  logic                     ctrl_write,
    input  logic                     ctrl_reload,
    output logic                     hit,
    output logic                     victim_dirty,
    output lc3b_cache_pkg::lc3b_word mem_addr,
    output lc3b_cache_pkg::lc3b_line mem_wdata,
    input  lc3b_cache_pkg::lc3b_line mem_rdata,
    input  logic                     mem_resp
);
    import lc3b_cache_pkg::*;

    // two ways, indexed [way][set]
    lc3b_line              data  [2][num_sets];
    lc3b_tag               tags  [2][num_sets];
    logic [num_sets-1:0]   valid [2];
    logic [num_sets-1:0]   dirty [2];
    logic [num_sets-1:0]   lru;

    lc3b_addr_u            addr_u;
    lc3b_addr_u            line_addr;
    lc3b_set               set;
    logic [offset_bits-2:0] word_idx;
    logic                  hit0;
    logic                  hit1;
    logic                  hit_way;
    logic                  lru_way;
    logic                  write_hit;
    logic                  fill;
    lc3b_line              line_sel;
    lc3b_line              merged;

    assign addr_u   = cpu_addr;
    assign set      = addr_u.fields.set;
    assign word_idx = addr_u.fields.offset[offset_bits-1:1];

    assign hit0    = valid[0][set] && (tags[0][set] == addr_u.fields.tag);
    assign hit1    = valid[1][set] && (tags[1][set] == addr_u.fields.tag);
    assign hit     = hit0 | hit1;
    assign hit_way = hit1;
    assign lru_way = lru[set];

    // only a valid line can need a write-back
    assign victim_dirty = valid[lru_way][set] & dirty[lru_way][set];

    assign cpu_resp  = cpu_strobe & ctrl_hit & hit;
    assign write_hit = cpu_resp & cpu_write;
    assign fill      = ctrl_reload & mem_resp;

    assign line_sel  = data[hit_way][set];
    assign cpu_rdata = line_sel[word_idx*word_bits +: word_bits];

    always_comb begin
        merged = line_sel;
        if (cpu_mask[0]) begin
            merged[word_idx*word_bits +: 8] = cpu_wdata[7:0];
        end
        if (cpu_mask[1]) begin
            merged[word_idx*word_bits + 8 +: 8] = cpu_wdata[15:8];
        end
    end

    // during write-back the address carries the victim's tag
    always_comb begin
        line_addr.fields.tag    = ctrl_write ? tags[lru_way][set] : addr_u.fields.tag;
        line_addr.fields.set    = set;
        line_addr.fields.offset = '0;
    end

    assign mem_addr  = line_addr.raw;
    assign mem_wdata = data[lru_way][set];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid[0] <= '0;
            valid[1] <= '0;
            dirty[0] <= '0;
            dirty[1] <= '0;
            lru      <= '0;
        end else begin
            if (cpu_resp) begin
                lru[set] <= ~hit_way;
                if (cpu_write) begin
                    dirty[hit_way][set] <= 1'b1;
                end
            end
            if (fill) begin
                valid[lru_way][set] <= 1'b1;
                dirty[lru_way][set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_hit) begin
            data[hit_way][set] <= merged;
        end
        if (fill) begin
            data[lru_way][set] <= mem_rdata;
            tags[lru_way][set] <= addr_u.fields.tag;
        end
    end

endmodule

`default_nettype wire

/* cache.sv */
`timescale 1ns/1ps
`default_nettype none

module cache (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_strobe,
    input  logic                     cpu_write,
    input  lc3b_cache_pkg::lc3b_mask cpu_mask,
    input  lc3b_cache_pkg::lc3b_word cpu_addr,
    input  lc3b_cache_pkg::lc3b_word cpu_wdata,
    output lc3b_cache_pkg::lc3b_word cpu_rdata,
    output logic                     cpu_resp,
    mem_if.cache                     mem
);

    logic hit;
    logic victim_dirty;
    logic ctrl_hit;
    logic ctrl_write;
    logic ctrl_reload;

    cache_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_strobe   (cpu_strobe),
        .cpu_write    (cpu_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_resp     (mem.resp),
        .ctrl_hit     (ctrl_hit),
        .ctrl_write   (ctrl_write),
        .ctrl_reload  (ctrl_reload),
        .mem_we       (mem.write),
        .mem_strobe   (mem.strobe)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_strobe   (cpu_strobe),
        .cpu_write    (cpu_write),
        .cpu_mask     (cpu_mask),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_rdata    (cpu_rdata),
        .cpu_resp     (cpu_resp),
        .ctrl_hit     (ctrl_hit),
        .ctrl_write   (ctrl_write),
        .ctrl_reload  (ctrl_reload),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_addr     (mem.addr),
        .mem_wdata    (mem.wdata),
        .mem_rdata    (mem.rdata),
        .mem_resp     (mem.resp)
    );

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    mem_if.arbiter                   req_a,
    mem_if.arbiter                   req_b,
    output logic                     pmem_strobe,
    output logic                     pmem_write,
    output lc3b_cache_pkg::lc3b_word pmem_addr,
    output lc3b_cache_pkg::lc3b_line pmem_wdata,
    input  lc3b_cache_pkg::lc3b_line pmem_rdata,
    input  logic                     pmem_resp
);

    typedef enum logic [1:0] {
        arb_idle,
        serve_a,
        serve_b
    } arb_state_t;

    arb_state_t state;
    logic       last_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= arb_idle;
            // pretend b went last so a has priority out of reset
            last_b <= 1'b1;
        end else begin
            case (state)
                arb_idle: begin
                    if (req_a.strobe && (!req_b.strobe || last_b)) begin
                        state <= serve_a;
                    end else if (req_b.strobe) begin
                        state <= serve_b;
                    end
                end
                serve_a: begin
                    if (pmem_resp) begin
                        state  <= arb_idle;
                        last_b <= 1'b0;
                    end
                end
                serve_b: begin
                    if (pmem_resp) begin
                        state  <= arb_idle;
                        last_b <= 1'b1;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    always_comb begin
        pmem_strobe = 1'b0;
        pmem_write  = 1'b0;
        pmem_addr   = req_a.addr;
        pmem_wdata  = req_a.wdata;
        if (state == serve_a) begin
            pmem_strobe = req_a.strobe;
            pmem_write  = req_a.write;
        end else if (state == serve_b) begin
            pmem_strobe = req_b.strobe;
            pmem_write  = req_b.write;
            pmem_addr   = req_b.addr;
            pmem_wdata  = req_b.wdata;
        end
    end

    // read data is shared, only the owner sees resp
    assign req_a.rdata = pmem_rdata;
    assign req_b.rdata = pmem_rdata;
    assign req_a.resp  = (state == serve_a) & pmem_resp;
    assign req_b.resp  = (state == serve_b) & pmem_resp;

endmodule

`default_nettype wire

/* lc3b_mem_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_mem_sys (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     cpu_a_strobe,
    input  logic                     cpu_a_write,
    input  lc3b_cache_pkg::lc3b_mask cpu_a_mask,
    input  lc3b_cache_pkg::lc3b_word cpu_a_addr,
    input  lc3b_cache_pkg::lc3b_word cpu_a_wdata,
    output lc3b_cache_pkg::lc3b_word cpu_a_rdata,
    output logic                     cpu_a_resp,

    input  logic                     cpu_b_strobe,
    input  logic                     cpu_b_write,
    input  lc3b_cache_pkg::lc3b_mask cpu_b_mask,
    input  lc3b_cache_pkg::lc3b_word cpu_b_addr,
    input  lc3b_cache_pkg::lc3b_word cpu_b_wdata,
    output lc3b_cache_pkg::lc3b_word cpu_b_rdata,
    output logic                     cpu_b_resp,

    output logic                     pmem_strobe,
    output logic                     pmem_write,
    output lc3b_cache_pkg::lc3b_word pmem_addr,
    output lc3b_cache_pkg::lc3b_line pmem_wdata,
    input  lc3b_cache_pkg::lc3b_line pmem_rdata,
    input  logic                     pmem_resp
);

    mem_if mem_a ();
    mem_if mem_b ();

    cache u_cache_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_strobe (cpu_a_strobe),
        .cpu_write  (cpu_a_write),
        .cpu_mask   (cpu_a_mask),
        .cpu_addr   (cpu_a_addr),
        .cpu_wdata  (cpu_a_wdata),
        .cpu_rdata  (cpu_a_rdata),
        .cpu_resp   (cpu_a_resp),
        .mem        (mem_a.cache)
    );

    cache u_cache_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_strobe (cpu_b_strobe),
        .cpu_write  (cpu_b_write),
        .cpu_mask   (cpu_b_mask),
        .cpu_addr   (cpu_b_addr),
        .cpu_wdata  (cpu_b_wdata),
        .cpu_rdata  (cpu_b_rdata),
        .cpu_resp   (cpu_b_resp),
        .mem        (mem_b.cache)
    );

    mem_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_a       (mem_a.arbiter),
        .req_b       (mem_b.arbiter),
        .pmem_strobe (pmem_strobe),
        .pmem_write  (pmem_write),
        .pmem_addr   (pmem_addr),
        .pmem_wdata  (pmem_wdata),
        .pmem_rdata  (pmem_rdata),
        .pmem_resp   (pmem_resp)
    );

endmodule

`default_nettype wire

/* tb_lc3b_mem_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_mem_sys;
    import lc3b_cache_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int port_accesses  = 150;

    logic     clk;
    logic     rst_n;
    logic     cpu_a_strobe;
    logic     cpu_a_write;
    lc3b_mask cpu_a_mask;
    lc3b_word cpu_a_addr;
    lc3b_word cpu_a_wdata;
    lc3b_word cpu_a_rdata;
    logic     cpu_a_resp;
    logic     cpu_b_strobe;
    logic     cpu_b_write;
    lc3b_mask cpu_b_mask;
    lc3b_word cpu_b_addr;
    lc3b_word cpu_b_wdata;
    lc3b_word cpu_b_rdata;
    logic     cpu_b_resp;
    logic     pmem_strobe;
    logic     pmem_write;
    lc3b_word pmem_addr;
    lc3b_line pmem_wdata;
    lc3b_line pmem_rdata;
    logic     pmem_resp;

    // flat byte image of the whole address space that ref_access keeps up to date
    logic [7:0]  image [0:65535];
    lc3b_line    mem_lines [0:4095];
    int          wb_count [0:4095];
    int          rd_total;
    int          wb_total;
    logic [31:0] lfsr;
    lc3b_word    exp_a[$];
    lc3b_word    exp_b[$];
    lc3b_word    st_addr [2][port_accesses];
    logic        st_wr   [2][port_accesses];
    lc3b_mask    st_mask [2][port_accesses];
    lc3b_word    st_data [2][port_accesses];

    lc3b_mem_sys UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_a_strobe (cpu_a_strobe),
        .cpu_a_write  (cpu_a_write),
        .cpu_a_mask   (cpu_a_mask),
        .cpu_a_addr   (cpu_a_addr),
        .cpu_a_wdata  (cpu_a_wdata),
        .cpu_a_rdata  (cpu_a_rdata),
        .cpu_a_resp   (cpu_a_resp),
        .cpu_b_strobe (cpu_b_strobe),
        .cpu_b_write  (cpu_b_write),
        .cpu_b_mask   (cpu_b_mask),
        .cpu_b_addr   (cpu_b_addr),
        .cpu_b_wdata  (cpu_b_wdata),
        .cpu_b_rdata  (cpu_b_rdata),
        .cpu_b_resp   (cpu_b_resp),
        .pmem_strobe  (pmem_strobe),
        .pmem_write   (pmem_write),
        .pmem_addr    (pmem_addr),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] fill_byte(input lc3b_word a);
        return a[7:0] ^ (a[15:8] * 8'h9d) ^ 8'h3c;
    endfunction

    function automatic lc3b_line image_line(input logic [11:0] idx);
        lc3b_line ln;
        for (int k = 0; k < 16; k++) begin
            ln[8*k +: 8] = image[{idx, k[3:0]}];
        end
        return ln;
    endfunction

    // words are little endian with the low byte at the even address
    function automatic lc3b_word ref_access(input lc3b_word addr, input logic wr,
                                            input lc3b_mask mask, input lc3b_word wdata);
        lc3b_word a0;
        lc3b_word a1;
        a0 = {addr[15:1], 1'b0};
        a1 = {addr[15:1], 1'b1};
        if (wr && mask[0]) begin
            image[a0] = wdata[7:0];
        end
        if (wr && mask[1]) begin
            image[a1] = wdata[15:8];
        end
        return {image[a1], image[a0]};
    endfunction

    task automatic end_in_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word expected);
        if (got !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic check_line(input string name, input lc3b_line got, input lc3b_line expected);
        if (got !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            end_in_failure();
        end
    endtask

    task automatic drive_port(input int port, input logic strobe, input logic wr,
                              input lc3b_mask mask, input lc3b_word addr, input lc3b_word wdata);
        if (port == 0) begin
            cpu_a_strobe = strobe;
            cpu_a_write  = wr;
            cpu_a_mask   = mask;
            cpu_a_addr   = addr;
            cpu_a_wdata  = wdata;
        end else begin
            cpu_b_strobe = strobe;
            cpu_b_write  = wr;
            cpu_b_mask   = mask;
            cpu_b_addr   = addr;
            cpu_b_wdata  = wdata;
        end
    endtask

    task automatic do_access(input int port, input lc3b_word addr, input logic wr,
                             input lc3b_mask mask, input lc3b_word wdata);
        lc3b_word expected;
        int       cycles;
        logic     done;
        expected = ref_access(addr, wr, mask, wdata);
        if (!wr && port == 0) begin
            exp_a.push_back(expected);
        end else if (!wr) begin
            exp_b.push_back(expected);
        end
        cycles = 0;
        done = 1'b0;
        @(posedge clk);
        #10;
        drive_port(port, 1'b1, wr, mask, addr, wdata);
        while (!done) begin
            @(negedge clk);
            done = (port == 0) ? cpu_a_resp : cpu_b_resp;
            cycles++;
            if (!done && cycles >= timeout_cycles) begin
                $display("timeout: port %0d got no cpu_resp for address 0x%h", port, addr);
                end_in_failure();
            end
        end
        @(posedge clk);
        #10;
        drive_port(port, 1'b0, 1'b0, 2'b00, 16'h0000, 16'h0000);
    endtask

    task automatic run_port(input int port);
        for (int i = 0; i < port_accesses; i++) begin
            do_access(port, st_addr[port][i], st_wr[port][i], st_mask[port][i], st_data[port][i]);
        end
    endtask

    // memory model answers 1 to 4 cycles after it sees the strobe
    initial begin
        logic [11:0] idx;
        logic [31:0] r;
        int          delay;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && pmem_strobe) begin
                check_count("pmem_addr offset", int'(pmem_addr[3:0]), 0);
                idx = pmem_addr[15:4];
                r = rand_bits(2);
                delay = int'(r[1:0]) + 1;
                if (pmem_write) begin
                    wb_total++;
                    wb_count[idx]++;
                    check_line("pmem_wdata", pmem_wdata, image_line(idx));
                    mem_lines[idx] = pmem_wdata;
                end else begin
                    rd_total++;
                end
                repeat (delay) @(posedge clk);
                #10;
                pmem_rdata = mem_lines[idx];
                pmem_resp  = 1'b1;
                @(posedge clk);
                #10;
                pmem_resp = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (cpu_a_strobe && cpu_a_resp && !cpu_a_write) begin
            if (exp_a.size() == 0) begin
                $display("port a returned read data with no read pending");
                end_in_failure();
            end else begin
                check_word("cpu_a_rdata", cpu_a_rdata, exp_a.pop_front());
            end
        end
        if (cpu_b_strobe && cpu_b_resp && !cpu_b_write) begin
            if (exp_b.size() == 0) begin
                $display("port b returned read data with no read pending");
                end_in_failure();
            end else begin
                check_word("cpu_b_rdata", cpu_b_rdata, exp_b.pop_front());
            end
        end
    end

    initial begin
        int          rd0;
        int          wb0;
        logic [31:0] r;
        lfsr = 32'hc5d03b31;
        rd_total = 0;
        wb_total = 0;
        rst_n = 1'b0;
        drive_port(0, 1'b0, 1'b0, 2'b00, 16'h0000, 16'h0000);
        drive_port(1, 1'b0, 1'b0, 2'b00, 16'h0000, 16'h0000);
        for (int i = 0; i < 65536; i++) begin
            image[i[15:0]] = fill_byte(i[15:0]);
        end
        for (int l = 0; l < 4096; l++) begin
            mem_lines[l[11:0]] = image_line(l[11:0]);
            wb_count[l[11:0]] = 0;
        end
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_count("pmem_strobe", int'(pmem_strobe), 0);
        check_count("pmem_write", int'(pmem_write), 0);
        check_count("cpu_a_resp", int'(cpu_a_resp), 0);
        check_count("cpu_b_resp", int'(cpu_b_resp), 0);

        // a cold line costs one memory read and then hits
        rd0 = rd_total;
        for (int w = 0; w < 8; w++) begin
            do_access(0, {12'h010, w[2:0], 1'b0}, 1'b0, 2'b00, 16'h0000);
        end
        check_count("memory reads", rd_total - rd0, 1);
        rd0 = rd_total;
        wb0 = wb_total;
        for (int w = 0; w < 8; w++) begin
            do_access(0, {12'h010, w[2:0], 1'b0}, 1'b0, 2'b00, 16'h0000);
        end
        check_count("memory reads", rd_total - rd0, 0);
        check_count("write-backs", wb_total - wb0, 0);

        // byte masks on port b
        do_access(1, 16'h8204, 1'b0, 2'b00, 16'h0000);
        do_access(1, 16'h8204, 1'b1, 2'b01, 16'ha1b2);
        do_access(1, 16'h8204, 1'b0, 2'b00, 16'h0000);
        do_access(1, 16'h8204, 1'b1, 2'b10, 16'hc3d4);
        do_access(1, 16'h8204, 1'b0, 2'b00, 16'h0000);
        do_access(1, 16'h8204, 1'b1, 2'b11, 16'he5f6);
        do_access(1, 16'h8204, 1'b0, 2'b00, 16'h0000);
        do_access(1, 16'h8206, 1'b0, 2'b00, 16'h0000);

        // three tags in set 2 where the second is least recent when the third comes
        wb0 = wb_total;
        do_access(0, 16'h0420, 1'b0, 2'b00, 16'h0000);
        do_access(0, 16'h0820, 1'b0, 2'b00, 16'h0000);
        do_access(0, 16'h0422, 1'b0, 2'b00, 16'h0000);
        rd0 = rd_total;
        do_access(0, 16'h0c20, 1'b0, 2'b00, 16'h0000);
        check_count("memory reads", rd_total - rd0, 1);
        rd0 = rd_total;
        do_access(0, 16'h0c24, 1'b0, 2'b00, 16'h0000);
        do_access(0, 16'h0424, 1'b0, 2'b00, 16'h0000);
        check_count("memory reads", rd_total - rd0, 0);
        do_access(0, 16'h0824, 1'b0, 2'b00, 16'h0000);
        check_count("memory reads", rd_total - rd0, 1);
        check_count("write-backs", wb_total - wb0, 0);

        // a dirty victim in set 5 goes back before the reload but a clean one does not
        do_access(0, 16'h1050, 1'b1, 2'b11, 16'h5aa5);
        do_access(0, 16'h10d0, 1'b0, 2'b00, 16'h0000);
        rd0 = rd_total;
        wb0 = wb_total;
        do_access(0, 16'h1150, 1'b0, 2'b00, 16'h0000);
        check_count("write-backs", wb_total - wb0, 1);
        check_count("write-backs of line 0x105", wb_count[12'h105], 1);
        check_count("memory reads", rd_total - rd0, 1);
        rd0 = rd_total;
        wb0 = wb_total;
        do_access(0, 16'h1050, 1'b0, 2'b00, 16'h0000);
        check_count("write-backs", wb_total - wb0, 0);
        check_count("memory reads", rd_total - rd0, 1);

        // port a stays in the lower half and port b in the upper half
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < port_accesses; i++) begin
                r = rand_bits(8);
                st_addr[p][i] = {p[0], 6'h2a, r[1:0], r[4:2], r[7:5], 1'b0};
                r = rand_bits(1);
                st_wr[p][i] = r[0];
                r = rand_bits(2);
                st_mask[p][i] = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
                r = rand_bits(16);
                st_data[p][i] = r[15:0];
            end
        end
        fork
            run_port(0);
            run_port(1);
        join
        @(negedge clk);
        check_count("pending port a reads", exp_a.size(), 0);
        check_count("pending port b reads", exp_b.size(), 0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* lc3b_mem_sys.f */
lc3b_cache_pkg.sv
mem_if.sv
cache_control.sv
cache_datapath.sv
cache.sv
mem_arbiter.sv
lc3b_mem_sys.sv
tb_lc3b_mem_sys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc3b_mem_sys
RTL_TOP   ?= lc3b_mem_sys
FILELIST  ?= lc3b_mem_sys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= lc3b_cache_pkg.sv mem_if.sv cache_control.sv cache_datapath.sv cache.sv \
             mem_arbiter.sv lc3b_mem_sys.sv
PASS_TEXT ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
